// File: ni_credit_counter.sv
`include "ni_defs.svh"

module ni_credit_counter (
    input  logic clk,
    input  logic reset,
    input  logic wr_i,
    input  logic credit_i,
    output logic full_o
);
    localparam int CNTW = $clog2(`NI_BUF_DEPTH + 1);
    localparam logic [CNTW-1:0] DEPTH = `NI_BUF_DEPTH;

    logic [CNTW-1:0] count;    // flits held downstream

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            if (wr_i && !credit_i && count != DEPTH) begin
                count <= count + 1'b1;
            end else if (!wr_i && credit_i && count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full_o = (count == DEPTH);

endmodule

// File: ni_defs.svh
`ifndef NI_DEFS_SVH
`define NI_DEFS_SVH

// data path and memory bus
`define NI_DW       32
`define NI_AW       32

// noc addressing
`define NI_EAW      8      // endpoint address
`define NI_CLASSW   2      // packet class

// largest packet is 2**NI_SIZEW - 1 words
`define NI_SIZEW    10

// flits the downstream buffer can hold
`define NI_BUF_DEPTH 4

`endif

// File: ni_flit_builder.sv
`include "ni_defs.svh"

module ni_flit_builder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   capture_i,
    input  logic [`NI_DW-1:0]      m_dat_i,
    input  logic                   emit_i,
    input  logic                   emit_hdr_i,
    input  logic                   emit_tail_i,
    input  logic [`NI_EAW-1:0]     dest_i,
    input  logic [`NI_CLASSW-1:0]  class_i,
    input  logic [`NI_EAW-1:0]     current_e_addr_i,
    output ni_flit_pkg::flit_t     flit_out_o,
    output logic                   flit_out_wr_o
);
    import ni_flit_pkg::*;

    logic [`NI_DW-1:0] data_q;   // last word read from memory
    flit_payload_u     hdr_pl;
    flit_payload_u     body_pl;
    flit_t             flit_nx;

    always_comb begin
        hdr_pl               = '0;
        hdr_pl.hdr.dst       = dest_i;
        hdr_pl.hdr.src       = current_e_addr_i;
        hdr_pl.hdr.pck_class = class_i;
        body_pl.data         = data_q;

        flit_nx.flag    = FLAG_BODY;
        flit_nx.payload = body_pl;
        if (emit_hdr_i) begin
            flit_nx.flag    = FLAG_HDR;
            flit_nx.payload = hdr_pl;
        end else if (emit_tail_i) begin
            flit_nx.flag = FLAG_TAIL;   // tail still carries the last word
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) data_q <= m_dat_i;
        if (emit_i) flit_out_o <= flit_nx;
    end

    // write strobe one cycle after emit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out_wr_o <= 1'b0;
        end else begin
            flit_out_wr_o <= emit_i;
        end
    end

endmodule

// File: ni_flit_pkg.sv
`include "ni_defs.svh"

package ni_flit_pkg;

    // flit kind, sits on top of the payload
    typedef logic [1:0] flit_flag_t;

    localparam flit_flag_t FLAG_HDR  = 2'b10;
    localparam flit_flag_t FLAG_BODY = 2'b00;
    localparam flit_flag_t FLAG_TAIL = 2'b01;

    // header word layout
    typedef struct packed {
        logic [`NI_DW-`NI_CLASSW-2*`NI_EAW-1:0] zero;    // unused, sent as zeros
        logic [`NI_CLASSW-1:0]                  pck_class;
        logic [`NI_EAW-1:0]                     src;
        logic [`NI_EAW-1:0]                     dst;
    } hdr_fields_t;

    // one payload word, header fields or plain data
    typedef union packed {
        hdr_fields_t       hdr;
        logic [`NI_DW-1:0] data;
    } flit_payload_u;

    typedef struct packed {
        flit_flag_t    flag;
        flit_payload_u payload;
    } flit_t;

endpackage

// File: ni_packetizer.f
+incdir+.
ni_flit_pkg.sv
ni_reg_pkg.sv
ni_regs.sv
ni_send_fsm.sv
ni_credit_counter.sv
ni_flit_builder.sv
ni_packetizer.sv
tb_ni_agents.sv
tb_ni_packetizer.sv

// File: ni_packetizer.sv
`include "ni_defs.svh"

module ni_packetizer (
    input  logic                   clk,
    input  logic                   reset,
    input  ni_reg_pkg::reg_addr_t  s_adr_i,
    input  logic [`NI_DW-1:0]      s_dat_i,
    input  logic                   s_we_i,
    input  logic                   s_stb_i,
    input  logic                   s_cyc_i,
    output logic [`NI_DW-1:0]      s_dat_o,
    output logic                   s_ack_o,
    output logic [`NI_AW-1:0]      m_adr_o,
    output logic [`NI_DW/8-1:0]    m_sel_o,
    output logic                   m_we_o,
    output logic                   m_cyc_o,
    output logic                   m_stb_o,
    input  logic [`NI_DW-1:0]      m_dat_i,
    input  logic                   m_ack_i,
    output ni_flit_pkg::flit_t     flit_out_o,
    output logic                   flit_out_wr_o,
    input  logic                   credit_in_i,
    input  logic [`NI_EAW-1:0]     current_e_addr_i,
    output logic                   irq_o
);
    logic                  start;
    logic [`NI_SIZEW-1:0]  size;
    logic [`NI_AW-1:0]     start_addr;
    logic [`NI_EAW-1:0]    dest;
    logic [`NI_CLASSW-1:0] pck_class;
    logic                  busy;
    logic                  done;
    logic                  emit;
    logic                  emit_hdr;
    logic                  emit_tail;
    logic                  capture;
    logic                  full;

    ni_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .s_adr_i      (s_adr_i),
        .s_dat_i      (s_dat_i),
        .s_we_i       (s_we_i),
        .s_stb_i      (s_stb_i),
        .s_cyc_i      (s_cyc_i),
        .busy_i       (busy),
        .done_i       (done),
        .s_dat_o      (s_dat_o),
        .s_ack_o      (s_ack_o),
        .start_o      (start),
        .size_o       (size),
        .start_addr_o (start_addr),
        .dest_o       (dest),
        .class_o      (pck_class),
        .irq_o        (irq_o)
    );

    ni_send_fsm u_send_fsm (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start),
        .size_i       (size),
        .start_addr_i (start_addr),
        .full_i       (full),
        .m_ack_i      (m_ack_i),
        .m_adr_o      (m_adr_o),
        .m_sel_o      (m_sel_o),
        .m_we_o       (m_we_o),
        .m_cyc_o      (m_cyc_o),
        .m_stb_o      (m_stb_o),
        .emit_o       (emit),
        .emit_hdr_o   (emit_hdr),
        .emit_tail_o  (emit_tail),
        .capture_o    (capture),
        .busy_o       (busy),
        .done_o       (done)
    );

    ni_credit_counter u_credit_counter (
        .clk      (clk),
        .reset    (reset),
        .wr_i     (emit),
        .credit_i (credit_in_i),
        .full_o   (full)
    );

    ni_flit_builder u_flit_builder (
        .clk              (clk),
        .reset            (reset),
        .capture_i        (capture),
        .m_dat_i          (m_dat_i),
        .emit_i           (emit),
        .emit_hdr_i       (emit_hdr),
        .emit_tail_i      (emit_tail),
        .dest_i           (dest),
        .class_i          (pck_class),
        .current_e_addr_i (current_e_addr_i),
        .flit_out_o       (flit_out_o),
        .flit_out_wr_o    (flit_out_wr_o)
    );

endmodule

// File: ni_reg_pkg.sv
package ni_reg_pkg;

    // word addresses on the slave port
    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t STATUS     = 3'd0;
    localparam reg_addr_t SEND_SIZE  = 3'd1;    // words
    localparam reg_addr_t SEND_START = 3'd2;    // byte address
    localparam reg_addr_t SEND_DEST  = 3'd3;
    localparam reg_addr_t SEND_CTRL  = 3'd4;    // any write starts a send
    localparam reg_addr_t ERRORS     = 3'd5;

    // class field sits above the destination in SEND_DEST
    localparam int DEST_CLASS_LSB = 8;

    // STATUS bits
    localparam int DONE_INT_EN = 0;
    localparam int ERR_INT_EN  = 1;
    localparam int DONE_ISR    = 2;    // write 1 to clear
    localparam int ERR_ISR     = 3;    // write 1 to clear, also drops error flags
    localparam int BUSY        = 4;    // read only

    // ERRORS bits
    localparam int SIZE_ERR    = 0;
    localparam int ILLEGAL_REQ = 1;

endpackage

// File: ni_regs.sv
`include "ni_defs.svh"

module ni_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  ni_reg_pkg::reg_addr_t  s_adr_i,
    input  logic [`NI_DW-1:0]      s_dat_i,
    input  logic                   s_we_i,
    input  logic                   s_stb_i,
    input  logic                   s_cyc_i,
    input  logic                   busy_i,
    input  logic                   done_i,
    output logic [`NI_DW-1:0]      s_dat_o,
    output logic                   s_ack_o,
    output logic                   start_o,
    output logic [`NI_SIZEW-1:0]   size_o,
    output logic [`NI_AW-1:0]      start_addr_o,
    output logic [`NI_EAW-1:0]     dest_o,
    output logic [`NI_CLASSW-1:0]  class_o,
    output logic                   irq_o
);
    import ni_reg_pkg::*;

    logic wr_req;
    logic ctrl_wr;
    logic status_wr;
    logic err_clr;
    logic size_big;     // last size write had bits above the size field
    logic size_bad;
    logic set_size_err;
    logic set_illegal;
    logic done_int_en;
    logic err_int_en;
    logic done_isr;
    logic err_isr;
    logic size_err;
    logic illegal_req;

    assign wr_req    = s_stb_i & s_cyc_i & s_we_i & ~s_ack_o;   // one write per access
    assign ctrl_wr   = wr_req & (s_adr_i == SEND_CTRL);
    assign status_wr = wr_req & (s_adr_i == STATUS);
    assign err_clr   = status_wr & s_dat_i[ERR_ISR];

    assign size_bad     = (size_o == '0) | size_big;
    assign set_size_err = ctrl_wr & size_bad;
    assign set_illegal  = ctrl_wr & busy_i;

    // two cycle access, ack for one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= s_stb_i & s_cyc_i & ~s_ack_o;
        end
    end

    // send setup and start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_o      <= 1'b0;
            size_o       <= '0;
            size_big     <= 1'b0;
            start_addr_o <= '0;
            dest_o       <= '0;
            class_o      <= '0;
        end else begin
            start_o <= ctrl_wr & ~size_bad & ~busy_i;
            if (wr_req) begin
                case (s_adr_i)
                    SEND_SIZE: begin
                        size_o   <= s_dat_i[`NI_SIZEW-1:0];
                        size_big <= |s_dat_i[`NI_DW-1:`NI_SIZEW];
                    end
                    SEND_START: start_addr_o <= s_dat_i[`NI_AW-1:0];
                    SEND_DEST: begin
                        dest_o  <= s_dat_i[`NI_EAW-1:0];
                        class_o <= s_dat_i[DEST_CLASS_LSB +: `NI_CLASSW];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // interrupt enables, flags and error flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_int_en <= 1'b0;
            err_int_en  <= 1'b0;
            done_isr    <= 1'b0;
            err_isr     <= 1'b0;
            size_err    <= 1'b0;
            illegal_req <= 1'b0;
        end else begin
            if (status_wr) begin
                done_int_en <= s_dat_i[DONE_INT_EN];
                err_int_en  <= s_dat_i[ERR_INT_EN];
            end
            if (done_i) begin
                done_isr <= 1'b1;           // a new packet end beats the clear
            end else if (status_wr && s_dat_i[DONE_ISR]) begin
                done_isr <= 1'b0;
            end
            if (set_size_err || set_illegal) begin
                err_isr <= 1'b1;
            end else if (err_clr) begin
                err_isr <= 1'b0;
            end
            if (set_size_err) begin
                size_err <= 1'b1;
            end else if (err_clr) begin
                size_err <= 1'b0;
            end
            if (set_illegal) begin
                illegal_req <= 1'b1;
            end else if (err_clr) begin
                illegal_req <= 1'b0;
            end
        end
    end

    // read mux
    always_comb begin
        s_dat_o = '0;
        case (s_adr_i)
            STATUS: begin
                s_dat_o[DONE_INT_EN] = done_int_en;
                s_dat_o[ERR_INT_EN]  = err_int_en;
                s_dat_o[DONE_ISR]    = done_isr;
                s_dat_o[ERR_ISR]     = err_isr;
                s_dat_o[BUSY]        = busy_i;
            end
            SEND_SIZE:  s_dat_o[`NI_SIZEW-1:0] = size_o;
            SEND_START: s_dat_o[`NI_AW-1:0]    = start_addr_o;
            SEND_DEST: begin
                s_dat_o[`NI_EAW-1:0]                   = dest_o;
                s_dat_o[DEST_CLASS_LSB +: `NI_CLASSW]  = class_o;
            end
            ERRORS: begin
                s_dat_o[SIZE_ERR]    = size_err;
                s_dat_o[ILLEGAL_REQ] = illegal_req;
            end
            default: s_dat_o = '0;      // SEND_CTRL reads back zero
        endcase
    end

    assign irq_o = (done_isr & done_int_en) | (err_isr & err_int_en);

endmodule

// File: ni_send_fsm.sv
`include "ni_defs.svh"

module ni_send_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  logic [`NI_SIZEW-1:0]    size_i,
    input  logic [`NI_AW-1:0]       start_addr_i,
    input  logic                    full_i,
    input  logic                    m_ack_i,
    output logic [`NI_AW-1:0]       m_adr_o,
    output logic [`NI_DW/8-1:0]     m_sel_o,
    output logic                    m_we_o,
    output logic                    m_cyc_o,
    output logic                    m_stb_o,
    output logic                    emit_o,
    output logic                    emit_hdr_o,
    output logic                    emit_tail_o,
    output logic                    capture_o,
    output logic                    busy_o,
    output logic                    done_o
);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_READ = 2'd2;
    localparam logic [1:0] ST_EMIT = 2'd3;

    localparam logic [`NI_AW-1:0] WORD_BYTES = `NI_DW / 8;

    logic [1:0]           state;
    logic [1:0]           state_nx;
    logic [`NI_SIZEW-1:0] word_cnt;   // words still to emit
    logic [`NI_AW-1:0]    addr_q;
    logic                 last_word;

    assign last_word = (word_cnt == `NI_SIZEW'(1));

    always_comb begin
        state_nx    = state;
        emit_o      = 1'b0;
        emit_hdr_o  = 1'b0;
        emit_tail_o = 1'b0;
        done_o      = 1'b0;
        case (state)
            ST_IDLE: if (start_i) state_nx = ST_HDR;
            ST_HDR: if (!full_i) begin
                emit_o     = 1'b1;
                emit_hdr_o = 1'b1;
                state_nx   = ST_READ;
            end
            ST_READ: if (m_ack_i) state_nx = ST_EMIT;
            ST_EMIT: if (!full_i) begin           // hold here while credits are out
                emit_o = 1'b1;
                if (last_word) begin
                    emit_tail_o = 1'b1;
                    done_o      = 1'b1;
                    state_nx    = ST_IDLE;
                end else begin
                    state_nx = ST_READ;           // next word only after this one left
                end
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            addr_q   <= '0;
        end else begin
            state <= state_nx;
            if (state == ST_IDLE && start_i) begin
                word_cnt <= size_i;
                addr_q   <= start_addr_i;
            end else begin
                if (capture_o) addr_q <= addr_q + WORD_BYTES;
                if (emit_o && !emit_hdr_o) word_cnt <= word_cnt - 1'b1;
            end
        end
    end

    // single read per word, drops the cycle after ack
    assign m_cyc_o   = (state == ST_READ);
    assign m_stb_o   = m_cyc_o;
    assign m_we_o    = 1'b0;
    assign m_sel_o   = '1;
    assign m_adr_o   = addr_q;
    assign capture_o = m_cyc_o & m_ack_i;
    assign busy_o    = (state != ST_IDLE);

endmodule

// File: run.sh
#!/bin/sh
# Compile the packetizer testbench with Verilator and run it.
# The run passes only when the simulation prints the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_ni_packetizer -f ni_packetizer.f

out=$(./obj_dir/Vtb_ni_packetizer)
echo "$out"
echo "$out" | grep -qx "test passed"

// File: tb_ni_agents.sv
`include "ni_defs.svh"

// memory slave, one read at a time, data is the address xor a fixed mask
module tb_ni_mem (
    input  logic              clk,
    input  logic              reset,
    input  logic [`NI_AW-1:0] m_adr_i,
    input  logic              m_cyc_i,
    input  logic              m_stb_i,
    output logic [`NI_DW-1:0] m_dat_o,
    output logic              m_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed = 32'hcf2d;
    logic   pending;        // request seen, wait cycles running
    int     wait_left;

    always @(posedge clk or posedge reset) begin : answer
        int   delay;
        logic fire;
        if (reset) begin
            m_ack_o   <= 1'b0;
            m_dat_o   <= '0;
            pending   <= 1'b0;
            wait_left <= 0;
        end else begin
            fire = 1'b0;
            if (m_cyc_i && m_stb_i && !m_ack_o) begin
                if (!pending) begin
                    delay = $random(seed) & 3;     // 0 to 3 wait cycles
                    fire = (delay == 0);
                    pending   <= (delay != 0);
                    wait_left <= delay - 1;
                end else if (wait_left == 0) begin
                    fire = 1'b1;
                    pending <= 1'b0;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
            m_ack_o <= fire;
            if (fire) m_dat_o <= m_adr_i ^ 32'ha5a50000;
        end
    end

endmodule

// flit sink, gives each flit back as a credit after a few cycles
module tb_ni_sink (
    input  logic clk,
    input  logic reset,
    input  logic flit_wr_i,
    input  logic hold_i,        // withhold all credits while high
    output logic credit_o
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed = 32'hcf2d;
    int     owed;       // flits taken, not yet credited
    int     timer;      // zero when no credit is scheduled

    always @(posedge clk or posedge reset) begin : give_back
        int n;
        if (reset) begin
            credit_o <= 1'b0;
            owed     <= 0;
            timer    <= 0;
        end else begin
            n = owed + (flit_wr_i ? 1 : 0);
            credit_o <= 1'b0;
            if (!hold_i) begin
                if (timer == 0) begin
                    if (n > 0) timer <= 1 + ({$random(seed)} % 6);
                end else if (timer == 1) begin
                    credit_o <= 1'b1;
                    n = n - 1;
                    timer <= 0;
                end else begin
                    timer <= timer - 1;
                end
            end
            owed <= n;
        end
    end

endmodule

// File: tb_ni_packetizer.sv
`include "ni_defs.svh"

module tb_ni_packetizer;
    timeunit 1ns;
    timeprecision 1ps;

    import ni_reg_pkg::*;

    localparam int                 LIMIT    = 2000;          // cycles per wait
    localparam logic [`NI_DW-1:0]  MEM_XOR  = 32'ha5a50000;
    localparam logic [`NI_EAW-1:0] OWN_ADDR = 8'h3c;

    logic                   clk;
    logic                   reset;
    logic [2:0]             s_adr;
    logic [`NI_DW-1:0]      s_dat;
    logic                   s_we;
    logic                   s_stb;
    logic                   s_cyc;
    logic [`NI_DW-1:0]      s_rdat;
    logic                   s_ack;
    logic [`NI_AW-1:0]      m_adr;
    logic [`NI_DW/8-1:0]    m_sel;
    logic                   m_we;
    logic                   m_cyc;
    logic                   m_stb;
    logic [`NI_DW-1:0]      m_dat;
    logic                   m_ack;
    logic [`NI_DW+1:0]      flit_out;   // flag on top of the payload
    logic                   flit_wr;
    logic                   credit;
    logic [`NI_EAW-1:0]     e_addr;
    logic                   irq;
    logic                   hold;

    integer            seed = 32'hcf2d;
    int                errors = 0;
    int                timeouts = 0;
    int                outstanding = 0;    // flits written minus credits back
    logic [`NI_DW+1:0] flits[$];
    logic              prev_stb = 1'b0;
    logic              prev_ack = 1'b0;
    logic [`NI_AW-1:0] prev_adr = '0;

    ni_packetizer ni_packetizer_i (
        .clk              (clk),
        .reset            (reset),
        .s_adr_i          (s_adr),
        .s_dat_i          (s_dat),
        .s_we_i           (s_we),
        .s_stb_i          (s_stb),
        .s_cyc_i          (s_cyc),
        .s_dat_o          (s_rdat),
        .s_ack_o          (s_ack),
        .m_adr_o          (m_adr),
        .m_sel_o          (m_sel),
        .m_we_o           (m_we),
        .m_cyc_o          (m_cyc),
        .m_stb_o          (m_stb),
        .m_dat_i          (m_dat),
        .m_ack_i          (m_ack),
        .flit_out_o       (flit_out),
        .flit_out_wr_o    (flit_wr),
        .credit_in_i      (credit),
        .current_e_addr_i (e_addr),
        .irq_o            (irq)
    );

    tb_ni_mem mem_i (
        .clk     (clk),
        .reset   (reset),
        .m_adr_i (m_adr),
        .m_cyc_i (m_cyc),
        .m_stb_i (m_stb),
        .m_dat_o (m_dat),
        .m_ack_o (m_ack)
    );

    tb_ni_sink sink_i (
        .clk       (clk),
        .reset     (reset),
        .flit_wr_i (flit_wr),
        .hold_i    (hold),
        .credit_o  (credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // flit capture, credit balance and master bus rules, mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (flit_wr) flits.push_back(flit_out);
            outstanding = outstanding + (flit_wr ? 1 : 0) - (credit ? 1 : 0);
            assert (outstanding <= `NI_BUF_DEPTH) else begin
                errors++;
                $display("more than %0d flits outstanding downstream", `NI_BUF_DEPTH);
            end
            assert (m_stb == m_cyc && !m_we) else begin
                errors++;
                $display("master strobe differs from cycle, or write enable is set");
            end
            assert (!m_cyc || m_sel == '1) else begin
                errors++;
                $display("master byte selects are not all ones during a read");
            end
            assert (!(prev_stb && !prev_ack && m_stb) || m_adr == prev_adr) else begin
                errors++;
                $display("master address changed while a read was waiting for ack");
            end
            prev_stb = m_stb;
            prev_ack = m_ack;
            prev_adr = m_adr;
        end
    end

    function automatic void compare_word(input string name, input logic [31:0] exp,
                                         input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout: no %s within %0d cycles", what, LIMIT);
    endtask

    // one slave access, ack and read data sampled mid cycle
    task automatic wb_access(input reg_addr_t adr, input logic [31:0] wdat, input logic we,
                             output logic [31:0] rdat);
        int n;
        @(posedge clk);
        s_adr <= adr;
        s_dat <= wdat;
        s_we  <= we;
        s_stb <= 1'b1;
        s_cyc <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!s_ack && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_ack) report_timeout("slave ack");
        rdat = s_rdat;
        @(posedge clk);
        s_stb <= 1'b0;
        s_cyc <= 1'b0;
        s_we  <= 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(adr, wdat, 1'b1, unused);
    endtask

    task automatic wb_read(input reg_addr_t adr, output logic [31:0] rdat);
        wb_access(adr, 32'h0, 1'b0, rdat);
    endtask

    task automatic check_irq(input string name, input logic exp);
        @(negedge clk);
        compare_word(name, {31'b0, exp}, {31'b0, irq});
    endtask

    task automatic wait_flit_count(input int count);
        int n;
        n = 0;
        while (flits.size() < count && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (flits.size() < count) report_timeout("complete packet");
    endtask

    task automatic wait_outstanding(input int value);
        int n;
        n = 0;
        while (outstanding != value && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (outstanding != value) report_timeout("expected credit balance");
    endtask

    // program one packet, optionally stall it on credits, then check every flit
    task automatic run_packet(input int words, input logic stall, input logic [31:0] en);
        logic [31:0]           rnd;
        logic [`NI_AW-1:0]     start;
        logic [`NI_EAW-1:0]    dest;
        logic [`NI_CLASSW-1:0] cls;
        logic [31:0]           rd;
        logic [1:0]            flag_exp;
        string                 tag;
        start = $random(seed) & 32'hfffffffc;    // word aligned
        rnd   = $random(seed);
        dest  = rnd[7:0];
        cls   = rnd[9:8];
        tag   = $sformatf("packet of %0d", words);
        wait_outstanding(0);
        flits.delete();
        wb_write(STATUS, en);
        wb_write(SEND_SIZE, words);
        wb_write(SEND_START, start);
        wb_write(SEND_DEST, {22'b0, cls, dest});
        @(posedge clk);
        hold <= stall;
        wb_write(SEND_CTRL, 32'h1);
        if (stall) begin
            wait_outstanding(`NI_BUF_DEPTH);
            wb_write(SEND_CTRL, 32'h1);              // second start while busy
            wb_read(ERRORS, rd);
            compare_word($sformatf("%s illegal request", tag), 32'h1 << ILLEGAL_REQ, rd);
            compare_word($sformatf("%s flits while stalled", tag), `NI_BUF_DEPTH, flits.size());
            wb_write(STATUS, en | (32'h1 << ERR_ISR));
            wb_read(ERRORS, rd);
            compare_word($sformatf("%s errors after clear", tag), 32'h0, rd);
            @(posedge clk);
            hold <= 1'b0;
        end
        wait_flit_count(words + 1);
        wb_read(STATUS, rd);
        compare_word($sformatf("%s status at end", tag), en | (32'h1 << DONE_ISR), rd);
        check_irq($sformatf("%s irq at end", tag), en[DONE_INT_EN]);
        compare_word($sformatf("%s flit count", tag), words + 1, flits.size());
        compare_word($sformatf("%s header flag", tag), 32'(2'b10), 32'(flits[0][33:32]));
        compare_word($sformatf("%s header", tag), {14'b0, cls, OWN_ADDR, dest}, flits[0][31:0]);
        for (int k = 0; k < words; k++) begin
            flag_exp = (k == words - 1) ? 2'b01 : 2'b00;    // tail carries the last word
            compare_word($sformatf("%s flag %0d", tag, k + 1), 32'(flag_exp),
                         32'(flits[k + 1][33:32]));
            compare_word($sformatf("%s data %0d", tag, k + 1), (start + 4 * k) ^ MEM_XOR,
                         flits[k + 1][31:0]);
        end
        wb_write(STATUS, en | (32'h1 << DONE_ISR));
        wb_read(STATUS, rd);
        compare_word($sformatf("%s status after clear", tag), en, rd);
        check_irq($sformatf("%s irq after clear", tag), 1'b0);
    endtask

    // start with a size that is zero or too large
    task automatic run_size_error(input logic [31:0] size);
        logic [31:0] rd;
        logic [31:0] en;
        string       tag;
        tag = $sformatf("size %0d", size);
        en  = 32'h1 << ERR_INT_EN;
        flits.delete();
        wb_write(STATUS, en);
        wb_write(SEND_SIZE, size);
        wb_write(SEND_CTRL, 32'h1);
        wb_read(ERRORS, rd);
        compare_word($sformatf("%s errors", tag), 32'h1 << SIZE_ERR, rd);
        wb_read(STATUS, rd);
        compare_word($sformatf("%s status", tag), en | (32'h1 << ERR_ISR), rd);
        check_irq($sformatf("%s irq", tag), 1'b1);
        repeat (20) @(negedge clk);                  // nothing may leave
        compare_word($sformatf("%s flits", tag), 32'h0, flits.size());
        wb_write(STATUS, en | (32'h1 << ERR_ISR));
        wb_read(ERRORS, rd);
        compare_word($sformatf("%s errors after clear", tag), 32'h0, rd);
        wb_read(STATUS, rd);
        compare_word($sformatf("%s status after clear", tag), en, rd);
        check_irq($sformatf("%s irq after clear", tag), 1'b0);
    endtask

    initial begin
        logic [31:0] rd;
        reset  = 1'b1;
        s_adr  = '0;
        s_dat  = '0;
        s_we   = 1'b0;
        s_stb  = 1'b0;
        s_cyc  = 1'b0;
        e_addr = OWN_ADDR;
        hold   = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        compare_word("reset irq", 32'h0, {31'b0, irq});
        compare_word("reset flit write", 32'h0, {31'b0, flit_wr});
        compare_word("reset master cycle", 32'h0, {31'b0, m_cyc});
        wb_read(STATUS, rd);
        compare_word("reset status", 32'h0, rd);
        wb_read(ERRORS, rd);
        compare_word("reset errors", 32'h0, rd);

        run_packet(1, 1'b0, 32'h1);
        run_packet(3, 1'b0, 32'h0);
        run_packet(7, 1'b0, 32'h1);
        run_packet(7, 1'b1, 32'h0);     // credits withheld, start while busy
        run_size_error(32'h0);
        run_size_error((32'h1 << `NI_SIZEW) | 32'h3);   // too large, low bits nonzero
        finish_run();
    end

endmodule
